//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] addr_t;
  typedef logic [xlen-1:0] instr_t; // Compressed instructions sit in the low half
  typedef logic [1:0] ctr_t;

  // addi x0, x0, 0
  localparam instr_t nop_instr = 32'h0000_0013;

  // Initial counter values for a freshly allocated BTB entry
  localparam ctr_t ctr_weak_taken = 2'b10;
  localparam ctr_t ctr_strong_taken = 2'b11;

  typedef enum logic {
    fb_idle,
    fb_wait
  } fb_state_e;

  // Full-length instructions have both low bits set, everything else is 16 bit
  function automatic addr_t instr_len(input instr_t instr);
    addr_t len;
    if (instr[1:0] == 2'b11) begin
      len = addr_t'(4);
    end else begin
      len = addr_t'(2);
    end
    return len;
  endfunction

endpackage

`default_nettype wire

//--- source/fetch_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_mem_if import fetch_pkg::*; ();

  logic valid;
  logic fence;
  addr_t addr;
  logic ready; // rdata holds the word at addr while valid and ready are high
  instr_t rdata;

  modport stage (
    output valid,
    output fence,
    output addr,
    input ready,
    input rdata
  );

  modport buffer (
    input valid,
    input fence,
    input addr,
    output ready,
    output rdata
  );

endinterface

`default_nettype wire

//--- source/bp_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bp_if import fetch_pkg::*; ();

  addr_t lookup_pc;
  logic hold;
  logic upd_valid;
  addr_t upd_pc;
  addr_t upd_target;
  logic upd_jump;
  logic upd_branch;
  logic upd_call;
  logic upd_ret;
  logic pred_taken;
  addr_t pred_target;
  logic pred_return;
  addr_t ret_target;

  modport stage (
    output lookup_pc, hold,
    output upd_valid, upd_pc, upd_target, upd_jump, upd_branch, upd_call, upd_ret,
    input pred_taken, pred_target, pred_return, ret_target
  );

  modport predictor (
    input lookup_pc, hold,
    input upd_valid, upd_pc, upd_target, upd_jump, upd_branch, upd_call, upd_ret,
    output pred_taken, pred_target, pred_return, ret_target
  );

endinterface

`default_nettype wire

//--- source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import fetch_pkg::*; #(
  parameter addr_t reset_vector = 32'h0
) (
  input logic clk,
  input logic rst,
  input logic trap,
  input addr_t mtvec,
  input logic mret,
  input addr_t mepc,
  input logic stall,
  input logic ex_valid,
  input addr_t ex_pc,
  input addr_t ex_target,
  input logic ex_jump,
  input logic ex_branch,
  input logic ex_call,
  input logic ex_ret,
  input logic ex_pred_taken,
  input addr_t ex_next_pc,
  input logic ex_fence,
  fetch_mem_if.stage mem,
  bp_if.stage bp,
  output logic f_valid,
  output addr_t f_pc,
  output instr_t f_instr,
  output logic f_taken
);

  addr_t pc_q;
  logic taken_q;
  logic pending_q; // Instruction at pc_q not delivered yet
  logic run_q;

  addr_t pc_d;
  logic taken_d;
  logic fence_d;
  logic fetch_new;
  logic ex_redirect;
  logic advance;
  logic deliver;

  // A taken jump that was not predicted, or predicted to the wrong place, and
  // a predicted-taken instruction that fell through all resolve to ex_target
  assign ex_redirect = ex_valid & ((ex_jump & (~ex_pred_taken | (ex_next_pc != ex_target))) |
                                   (~ex_jump & ex_pred_taken));
  assign advance = ~stall & ~pending_q;

  always_comb begin
    pc_d = pc_q;
    taken_d = taken_q;
    fence_d = 1'b0;
    fetch_new = 1'b1;
    if (trap) begin
      pc_d = mtvec;
      taken_d = 1'b0;
    end else if (mret) begin
      pc_d = mepc;
      taken_d = 1'b0;
    end else if (ex_redirect) begin
      pc_d = ex_target;
      taken_d = 1'b0;
    end else if (bp.pred_return) begin
      pc_d = bp.ret_target;
      taken_d = 1'b1;
    end else if (bp.pred_taken) begin
      pc_d = bp.pred_target;
      taken_d = 1'b1;
    end else if (ex_valid & ex_fence) begin
      pc_d = ex_pc; // Refetch through an emptied buffer
      taken_d = 1'b0;
      fence_d = 1'b1;
    end else if (advance) begin
      pc_d = pc_q + instr_len(f_instr);
      taken_d = 1'b0;
    end else begin
      fetch_new = 1'b0;
    end
  end

  // Only a fresh or still outstanding pc may be delivered, never one twice
  assign deliver = run_q & mem.ready & ~stall & (pending_q | fetch_new);

  assign mem.valid = run_q;
  assign mem.addr = pc_d;
  assign mem.fence = fence_d;

  // Predictions are only wanted when the stage is free to follow them
  assign bp.lookup_pc = pc_q;
  assign bp.hold = stall | pending_q | trap | mret | ex_redirect;
  assign bp.upd_valid = ex_valid;
  assign bp.upd_pc = ex_pc;
  assign bp.upd_target = ex_target;
  assign bp.upd_jump = ex_jump;
  assign bp.upd_branch = ex_branch;
  assign bp.upd_call = ex_call;
  assign bp.upd_ret = ex_ret;

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc_q <= reset_vector;
      taken_q <= 1'b0;
      pending_q <= 1'b1; // The reset vector still has to be fetched
      run_q <= 1'b0;
      f_valid <= 1'b0;
      f_pc <= reset_vector;
      f_instr <= nop_instr;
      f_taken <= 1'b0;
    end else begin
      run_q <= 1'b1;
      pc_q <= pc_d;
      taken_q <= taken_d;
      pending_q <= (pending_q | fetch_new) & ~deliver;
      f_valid <= deliver;
      if (deliver) begin
        f_pc <= pc_d;
        f_instr <= mem.rdata;
        f_taken <= taken_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor import fetch_pkg::*; #(
  parameter int btb_entries = 16,
  parameter int ras_depth = 4
) (
  input logic clk,
  input logic rst,
  bp_if.predictor bp
);

  localparam int idx_w = $clog2(btb_entries);
  localparam int tag_w = xlen - idx_w - 1;
  localparam int cnt_w = $clog2(ras_depth + 1);

  typedef logic [idx_w-1:0] idx_t;
  typedef logic [tag_w-1:0] tag_t;

  logic [btb_entries-1:0] btb_valid;
  tag_t btb_tag [btb_entries];
  addr_t btb_target [btb_entries];
  ctr_t btb_ctr [btb_entries];
  logic btb_ret [btb_entries];

  addr_t ras [ras_depth]; // Entry 0 is the top of the stack
  logic [cnt_w-1:0] ras_cnt;

  idx_t look_idx;
  tag_t look_tag;
  logic look_hit;
  logic ret_hit;
  idx_t upd_idx;
  tag_t upd_tag;
  logic upd_hit;
  logic push;
  logic pop;

  // Indexed by halfword so compressed neighbours do not alias
  assign look_idx = bp.lookup_pc[idx_w:1];
  assign look_tag = bp.lookup_pc[xlen-1:idx_w+1];
  assign upd_idx = bp.upd_pc[idx_w:1];
  assign upd_tag = bp.upd_pc[xlen-1:idx_w+1];

  assign look_hit = btb_valid[look_idx] & (btb_tag[look_idx] == look_tag);
  assign upd_hit = btb_valid[upd_idx] & (btb_tag[upd_idx] == upd_tag);
  assign ret_hit = look_hit & btb_ret[look_idx] & (ras_cnt != '0);

  assign bp.pred_return = ~bp.hold & ret_hit;
  assign bp.pred_taken = ~bp.hold & look_hit & ~ret_hit & btb_ctr[look_idx][1];
  assign bp.pred_target = btb_target[look_idx];
  assign bp.ret_target = ras[0];

  // The stack is popped when fetch follows a return prediction
  assign push = bp.upd_valid & bp.upd_call;
  assign pop = bp.pred_return;

  always_ff @(posedge clk) begin
    if (!rst) begin
      btb_valid <= '0;
      ras_cnt <= '0;
    end else begin
      if (bp.upd_valid & bp.upd_jump) begin
        btb_valid[upd_idx] <= 1'b1;
      end
      if (push & ~pop & (ras_cnt != cnt_w'(ras_depth))) begin
        ras_cnt <= ras_cnt + 1'b1;
      end else if (pop & ~push) begin
        ras_cnt <= ras_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bp.upd_valid) begin
      if (bp.upd_jump) begin
        btb_tag[upd_idx] <= upd_tag;
        btb_target[upd_idx] <= bp.upd_target;
        btb_ret[upd_idx] <= bp.upd_ret;
        if (!upd_hit) begin
          btb_ctr[upd_idx] <= bp.upd_branch ? ctr_weak_taken : ctr_strong_taken;
        end else if (btb_ctr[upd_idx] != 2'b11) begin
          btb_ctr[upd_idx] <= btb_ctr[upd_idx] + 2'd1;
        end
      end else if (upd_hit & bp.upd_branch & (btb_ctr[upd_idx] != 2'b00)) begin
        btb_ctr[upd_idx] <= btb_ctr[upd_idx] - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      ras[0] <= bp.upd_pc + addr_t'(4);
      if (!pop) begin
        for (int i = 1; i < ras_depth; i++) begin
          ras[i] <= ras[i-1];
        end
      end
    end else if (pop) begin
      for (int i = 0; i < ras_depth - 1; i++) begin
        ras[i] <= ras[i+1];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer import fetch_pkg::*; (
  input logic clk,
  input logic rst,
  fetch_mem_if.buffer mem,
  output logic imem_valid,
  output addr_t imem_addr,
  input logic imem_ready,
  input instr_t imem_rdata
);

  fb_state_e state_q;
  logic buf_valid_q;
  addr_t buf_addr_q;
  instr_t buf_data_q;
  addr_t req_addr_q;
  logic stale_q; // Outstanding response no longer wanted

  logic hit;
  logic stale_now;

  // A fence in the lookup cycle already counts as an empty buffer
  assign hit = (state_q == fb_idle) & buf_valid_q & ~mem.fence & (buf_addr_q == mem.addr);
  assign stale_now = stale_q | mem.fence | (mem.valid & (mem.addr != req_addr_q));

  assign mem.ready = mem.valid & hit;
  assign mem.rdata = buf_data_q;

  assign imem_valid = (state_q == fb_wait);
  assign imem_addr = req_addr_q; // Held steady for the whole wait

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q <= fb_idle;
      buf_valid_q <= 1'b0;
      stale_q <= 1'b0;
    end else begin
      case (state_q)
        fb_idle: begin
          if (mem.fence) begin
            buf_valid_q <= 1'b0;
          end
          if (mem.valid & ~hit) begin
            state_q <= fb_wait;
            stale_q <= 1'b0;
          end
        end
        fb_wait: begin
          if (mem.fence) begin
            buf_valid_q <= 1'b0;
          end
          stale_q <= stale_now;
          if (imem_ready) begin
            state_q <= fb_idle; // A redirected address misses and is requested from idle
            if (!stale_now) begin
              buf_valid_q <= 1'b1;
            end
          end
        end
        default: state_q <= fb_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == fb_idle) && mem.valid && !hit) begin
      req_addr_q <= mem.addr;
    end
    if ((state_q == fb_wait) && imem_ready && !stale_now) begin
      buf_addr_q <= req_addr_q;
      buf_data_q <= imem_rdata;
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import fetch_pkg::*; #(
  parameter addr_t reset_vector = 32'h0,
  parameter int btb_entries = 16,
  parameter int ras_depth = 4
) (
  input logic clk,
  input logic rst,
  input logic trap,
  input addr_t mtvec,
  input logic mret,
  input addr_t mepc,
  input logic stall,
  input logic ex_valid,
  input addr_t ex_pc,
  input addr_t ex_target,
  input logic ex_jump,
  input logic ex_branch,
  input logic ex_call,
  input logic ex_ret,
  input logic ex_pred_taken,
  input addr_t ex_next_pc,
  input logic ex_fence,
  output logic imem_valid,
  output addr_t imem_addr,
  input logic imem_ready,
  input instr_t imem_rdata,
  output logic f_valid,
  output addr_t f_pc,
  output instr_t f_instr,
  output logic f_taken
);

  fetch_mem_if mem_bus ();
  bp_if bp_bus ();

  fetch_stage #(
    .reset_vector(reset_vector)
  ) u_stage (
    .clk(clk),
    .rst(rst),
    .trap(trap),
    .mtvec(mtvec),
    .mret(mret),
    .mepc(mepc),
    .stall(stall),
    .ex_valid(ex_valid),
    .ex_pc(ex_pc),
    .ex_target(ex_target),
    .ex_jump(ex_jump),
    .ex_branch(ex_branch),
    .ex_call(ex_call),
    .ex_ret(ex_ret),
    .ex_pred_taken(ex_pred_taken),
    .ex_next_pc(ex_next_pc),
    .ex_fence(ex_fence),
    .mem(mem_bus.stage),
    .bp(bp_bus.stage),
    .f_valid(f_valid),
    .f_pc(f_pc),
    .f_instr(f_instr),
    .f_taken(f_taken)
  );

  branch_predictor #(
    .btb_entries(btb_entries),
    .ras_depth(ras_depth)
  ) u_predictor (
    .clk(clk),
    .rst(rst),
    .bp(bp_bus.predictor)
  );

  fetch_buffer u_buffer (
    .clk(clk),
    .rst(rst),
    .mem(mem_bus.buffer),
    .imem_valid(imem_valid),
    .imem_addr(imem_addr),
    .imem_ready(imem_ready),
    .imem_rdata(imem_rdata)
  );

endmodule

`default_nettype wire

//--- sim/fetch_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_asserts import fetch_pkg::*; (
  input logic clk,
  input logic rst,
  input logic f_valid,
  input logic imem_valid,
  input addr_t imem_addr,
  input logic imem_ready
);

  // Nothing is delivered in the cycle after a reset cycle
  a_reset_quiet: assert property (@(posedge clk) !rst |=> !f_valid)
    else $error("f_valid high right after reset");

  a_addr_even: assert property (@(posedge clk) disable iff (!rst) imem_valid |-> !imem_addr[0])
    else $error("odd instruction memory address");

  // An open request keeps its address until the memory answers
  a_req_stable: assert property (@(posedge clk) disable iff (!rst)
      imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr))
    else $error("instruction memory request changed before ready");

endmodule

bind fetch_unit fetch_unit_asserts u_asserts (
  .clk(clk),
  .rst(rst),
  .f_valid(f_valid),
  .imem_valid(imem_valid),
  .imem_addr(imem_addr),
  .imem_ready(imem_ready)
);

`default_nettype wire

//--- sim/fetch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb import fetch_pkg::*; ();

  typedef enum {
    p_none, p_trap, p_mret, p_trap_ex, p_jump, p_call, p_ret, p_fence, p_stall
  } pulse_e;

  localparam int reset_cycles = 8;
  localparam int stall_cycles = 6;
  localparam int max_lat = 3;

  logic clk, rst, trap, mret, stall, ex_valid, ex_jump, ex_branch, ex_call, ex_ret;
  logic ex_pred_taken, ex_fence, imem_valid, f_valid, f_taken;
  addr_t mtvec, mepc, ex_pc, ex_target, ex_next_pc, imem_addr, f_pc;
  instr_t f_instr;
  logic imem_ready = 1'b0;
  instr_t imem_rdata = '0;

  logic [15:0] mem16 [1024]; // Program as halfwords, so compressed words can sit anywhere
  int seed = 32'hc3f64db2;
  int wait_cnt = 0;
  logic busy = 1'b0;
  int cycles = 0;
  int limit = 0;
  int req_count = 0;
  int count_before = 0;
  addr_t last_req_addr = '0;
  logic valid_seen = 1'b0;

  string row_name[$];
  pulse_e row_kind[$];
  addr_t row_arg[$];
  addr_t row_target[$];
  addr_t row_pc[$];
  logic row_taken[$];

  fetch_unit #(.reset_vector(32'h100), .btb_entries(16), .ras_depth(4)) uut (
    .clk(clk), .rst(rst), .trap(trap), .mtvec(mtvec), .mret(mret), .mepc(mepc),
    .stall(stall), .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_target(ex_target),
    .ex_jump(ex_jump), .ex_branch(ex_branch), .ex_call(ex_call), .ex_ret(ex_ret),
    .ex_pred_taken(ex_pred_taken), .ex_next_pc(ex_next_pc), .ex_fence(ex_fence),
    .imem_valid(imem_valid), .imem_addr(imem_addr), .imem_ready(imem_ready),
    .imem_rdata(imem_rdata), .f_valid(f_valid), .f_pc(f_pc), .f_instr(f_instr),
    .f_taken(f_taken)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic instr_t prog_word(input addr_t a);
    logic [9:0] h;
    h = a[10:1];
    return {mem16[h + 10'd1], mem16[h]};
  endfunction

  // Memory answers each request after 1 to 3 cycles
  always @(posedge clk) begin
    if (!rst) begin
      imem_ready <= 1'b0;
      busy <= 1'b0;
    end else if (imem_ready) begin
      imem_ready <= 1'b0;
      busy <= 1'b0;
    end else if (imem_valid && !busy) begin
      busy <= 1'b1;
      wait_cnt <= 1 + int'($unsigned($random(seed)) % 3);
    end else if (busy && wait_cnt > 1) begin
      wait_cnt <= wait_cnt - 1;
    end else if (busy) begin
      imem_ready <= 1'b1;
      imem_rdata <= prog_word(imem_addr);
    end
  end

  always @(negedge clk) begin
    if (imem_valid && !valid_seen) begin
      req_count = req_count + 1;
      last_req_addr = imem_addr;
    end
    valid_seen = imem_valid;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: no delivery from the fetch unit within %0d cycles", limit);
      $display("TEST FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic fail_stop();
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic add_row(input string name, input pulse_e kind, input addr_t arg,
                         input addr_t target, input addr_t pc, input logic taken);
    row_name.push_back(name);
    row_kind.push_back(kind);
    row_arg.push_back(arg);
    row_target.push_back(target);
    row_pc.push_back(pc);
    row_taken.push_back(taken);
  endtask

  task automatic clear_inputs();
    trap <= 1'b0;
    mret <= 1'b0;
    stall <= 1'b0;
    ex_valid <= 1'b0;
    ex_jump <= 1'b0;
    ex_branch <= 1'b0;
    ex_call <= 1'b0;
    ex_ret <= 1'b0;
    ex_pred_taken <= 1'b0;
    ex_fence <= 1'b0;
  endtask

  task automatic apply_pulse(input pulse_e kind, input addr_t arg, input addr_t target);
    @(posedge clk);
    case (kind)
      p_trap: begin
        trap <= 1'b1;
        mtvec <= arg;
      end
      p_mret: begin
        mret <= 1'b1;
        mepc <= arg;
      end
      p_trap_ex: begin
        trap <= 1'b1;
        mtvec <= arg;
        ex_valid <= 1'b1;
        ex_jump <= 1'b1;
        ex_pc <= 32'h280;
        ex_target <= target;
        ex_next_pc <= 32'h284;
      end
      p_jump, p_call, p_ret: begin
        ex_valid <= 1'b1;
        ex_jump <= 1'b1;
        ex_pc <= arg;
        ex_target <= target;
        ex_pred_taken <= (kind != p_jump);
        ex_next_pc <= (kind == p_jump) ? arg + 32'd4 : target; // Calls and returns were right
        ex_call <= (kind == p_call);
        ex_ret <= (kind == p_ret);
      end
      p_fence: begin
        ex_valid <= 1'b1;
        ex_fence <= 1'b1;
        ex_pc <= arg;
        count_before = req_count;
      end
      p_stall: stall <= 1'b1;
      default: ;
    endcase
    if (kind == p_stall) begin
      repeat (stall_cycles) begin
        @(negedge clk);
        check_bit("stall_hold f_valid", 1'b0, f_valid);
      end
    end
    @(posedge clk);
    clear_inputs();
  endtask

  task automatic wait_delivery();
    do begin
      @(negedge clk);
    end while (!f_valid);
  endtask

  initial begin
    logic [9:0] h;
    rst <= 1'b0;
    mtvec <= '0;
    mepc <= '0;
    ex_pc <= '0;
    ex_target <= '0;
    ex_next_pc <= '0;
    clear_inputs();
    // Each 8-byte block holds one full-length word and then two compressed halfwords
    for (int i = 0; i < 1024; i++) begin
      h = 10'(i);
      case (h[1:0])
        2'd0: mem16[i] = {h, 4'h0, 2'b11};
        2'd1: mem16[i] = {h, 6'h2a};
        default: mem16[i] = {h, 4'h5, 2'b01};
      endcase
    end
    add_row("seq_0", p_none, '0, '0, 32'h100, 1'b0);
    add_row("seq_1", p_none, '0, '0, 32'h104, 1'b0);
    add_row("seq_2", p_none, '0, '0, 32'h106, 1'b0);
    add_row("seq_3", p_none, '0, '0, 32'h108, 1'b0);
    add_row("trap", p_trap, 32'h200, '0, 32'h200, 1'b0);
    add_row("seq_4", p_none, '0, '0, 32'h204, 1'b0);
    add_row("mret", p_mret, 32'h10c, '0, 32'h10c, 1'b0);
    add_row("seq_5", p_none, '0, '0, 32'h10e, 1'b0);
    add_row("trap_over_ex", p_trap_ex, 32'h240, 32'h300, 32'h240, 1'b0);
    add_row("mispredict", p_jump, 32'h2a0, 32'h320, 32'h320, 1'b0);
    add_row("refetch_jump", p_trap, 32'h2a0, '0, 32'h2a0, 1'b0);
    add_row("predicted", p_none, '0, '0, 32'h320, 1'b1);
    add_row("call_update", p_call, 32'h340, 32'h400, 32'h324, 1'b0);
    // The return last went elsewhere, so only the stack can supply 32'h344
    add_row("ret_update", p_ret, 32'h364, 32'h3c0, 32'h326, 1'b0);
    add_row("return_fetch", p_trap, 32'h364, '0, 32'h364, 1'b0);
    add_row("return_pred", p_none, '0, '0, 32'h344, 1'b1);
    add_row("fence", p_fence, 32'h344, '0, 32'h344, 1'b0);
    add_row("seq_6", p_none, '0, '0, 32'h346, 1'b0);
    add_row("stall", p_stall, '0, '0, 32'h348, 1'b0);
    add_row("seq_7", p_none, '0, '0, 32'h34c, 1'b0);
    // A redirect in flight can cost two memory round trips
    limit = reset_cycles + stall_cycles + row_name.size() * 2 * (max_lat + 2 + 4);
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < row_name.size(); i++) begin
      apply_pulse(row_kind[i], row_arg[i], row_target[i]);
      wait_delivery();
      check_addr({row_name[i], " f_pc"}, row_pc[i], f_pc);
      check_bit({row_name[i], " f_taken"}, row_taken[i], f_taken);
      check_instr({row_name[i], " f_instr"}, prog_word(row_pc[i]), f_instr);
      if (row_kind[i] == p_fence) begin
        check_bit("fence refetch request", 1'b1, req_count > count_before);
        check_addr("fence refetch address", row_arg[i], last_req_addr);
      end
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_fetch.f
source/fetch_pkg.sv
source/fetch_mem_if.sv
source/bp_if.sv
source/fetch_stage.sv
source/branch_predictor.sv
source/fetch_buffer.sv
source/fetch_unit.sv
sim/fetch_unit_asserts.sv
sim/fetch_unit_tb.sv

//--- Makefile
TOP = fetch_unit_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f rv_fetch.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST OK" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
